//--- verilog/r10k_pkg.sv
/*
  Sizes and types shared by the rename core.
  Tag and index widths follow the register-file sizes below; change them together.
*/
package r10k_pkg;

  // register-file and reorder-buffer sizes
  localparam int num_arch = 8;
  localparam int num_phys = 32;
  localparam int num_rob  = 8;

  // architectural register number
  typedef logic [$clog2(num_arch)-1:0] arch_reg_t;

  // physical register tag
  typedef logic [$clog2(num_phys)-1:0] phys_tag_t;

  // reorder-buffer slot index, wraps modulo num_rob
  typedef logic [$clog2(num_rob)-1:0] rob_idx_t;

  // occupancy, 0 up to num_rob inclusive
  typedef logic [$clog2(num_rob):0] rob_count_t;

  // reorder-buffer mode
  typedef enum logic {
    rob_run,
    rob_squash
  } rob_state_t;

endpackage

//--- verilog/reorder_buffer.sv
/*
  Circular reorder buffer holding arch, T and T_old per entry.
  A mispredict must name a live entry; younger entries are undone one per cycle.
  Dispatch and retire are blocked during the mispredict cycle and while busy.
*/
`timescale 1ns/100ps

module reorder_buffer (
  input  logic                clock,
  input  logic                reset,
  input  logic                dispatch_valid,
  input  r10k_pkg::arch_reg_t dispatch_arch,
  input  r10k_pkg::phys_tag_t alloc_t,
  input  r10k_pkg::phys_tag_t alloc_t_old,
  input  logic                free_empty,
  input  logic                retire,
  input  logic                mispredict,
  input  r10k_pkg::rob_idx_t  mispredict_rob_idx,
  output logic                dispatch_ready,
  output r10k_pkg::rob_idx_t  dispatch_rob_idx,
  output logic                alloc,
  output logic                retire_valid,
  output r10k_pkg::phys_tag_t retire_t_old,
  output logic                free_push,
  output r10k_pkg::phys_tag_t free_push_t,
  output logic                busy,
  output logic                undo_valid,
  output r10k_pkg::arch_reg_t undo_arch,
  output r10k_pkg::phys_tag_t undo_t,
  output r10k_pkg::phys_tag_t undo_t_old,
  output r10k_pkg::rob_idx_t  head_idx
);
  import r10k_pkg::*;

  // entry payload
  arch_reg_t  ent_arch  [num_rob];
  phys_tag_t  ent_t     [num_rob];
  phys_tag_t  ent_t_old [num_rob];

  // control state
  rob_idx_t   head;
  rob_idx_t   tail;
  rob_count_t count;
  rob_state_t state;
  rob_idx_t   squash_stop;

  rob_idx_t   tail_prev;
  rob_idx_t   branch_next;
  logic       full;
  logic       do_retire;
  logic       take_mispredict;

  assign full      = (count == rob_count_t'(num_rob));
  assign busy      = (state == rob_squash);
  assign tail_prev = tail - 1'b1;

  // dispatch side
  assign dispatch_ready   = !full && !free_empty && !busy && !mispredict;
  assign alloc            = dispatch_valid && dispatch_ready;
  assign dispatch_rob_idx = tail;

  // retire side, oldest entry at head
  assign retire_valid = (count != '0) && !busy && !mispredict;
  assign do_retire    = retire && retire_valid;
  assign retire_t_old = ent_t_old[head];
  assign head_idx     = head;

  // undo stream comes from the youngest entry
  assign undo_valid = busy;
  assign undo_arch  = ent_arch[tail_prev];
  assign undo_t     = ent_t[tail_prev];
  assign undo_t_old = ent_t_old[tail_prev];

  // tail lands one past the branch once the walk-back is done
  assign branch_next = mispredict_rob_idx + 1'b1;
  // no walk-back when the branch is already the youngest entry
  assign take_mispredict = mispredict && !busy && (branch_next != tail);

  // retire and undo never overlap, so one push port is enough
  assign free_push   = do_retire || undo_valid;
  assign free_push_t = undo_valid ? undo_t : retire_t_old;

  always_ff @(posedge clock) begin
    if (reset) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      state       <= rob_run;
      squash_stop <= '0;
    end else begin
      case (state)
        rob_run: begin
          if (do_retire) begin
            head <= head + 1'b1;
          end
          if (alloc) begin
            tail <= tail + 1'b1;
          end
          if (alloc && !do_retire) begin
            count <= count + 1'b1;
          end else if (!alloc && do_retire) begin
            count <= count - 1'b1;
          end
          if (take_mispredict) begin
            state       <= rob_squash;
            squash_stop <= branch_next;
          end
        end
        rob_squash: begin
          // pop one younger entry per cycle
          tail  <= tail_prev;
          count <= count - 1'b1;
          if (tail_prev == squash_stop) begin
            state <= rob_run;
          end
        end
        default: begin
          state <= rob_run;
        end
      endcase
    end
  end

  // payload written at the tail on an accepted dispatch
  always_ff @(posedge clock) begin
    if (alloc) begin
      ent_arch[tail]  <= dispatch_arch;
      ent_t[tail]     <= alloc_t;
      ent_t_old[tail] <= alloc_t_old;
    end
  end

endmodule

//--- verilog/map_table.sv
/*
  Architectural-to-physical map, identity after reset.
  Single write port; the read is the registered value with no write bypass,
  so a write and a dependent read must not share a cycle.
*/
`timescale 1ns/100ps

module map_table (
  input  logic                clock,
  input  logic                reset,
  input  r10k_pkg::arch_reg_t read_arch,
  output r10k_pkg::phys_tag_t read_t,
  input  logic                write_en,
  input  r10k_pkg::arch_reg_t write_arch,
  input  r10k_pkg::phys_tag_t write_t
);
  import r10k_pkg::*;

  // one tag per architectural register
  phys_tag_t map [num_arch];

  // current mapping, seen as T_old by dispatch
  assign read_t = map[read_arch];

  always_ff @(posedge clock) begin
    if (reset) begin
      // arch register i starts in physical register i
      for (int i = 0; i < num_arch; i++) begin
        map[i] <= phys_tag_t'(i);
      end
    end else if (write_en) begin
      map[write_arch] <= write_t;
    end
  end

endmodule

//--- verilog/free_list.sv
/*
  Circular queue of free physical tags, num_phys deep.
  Reset loads tags num_arch up to num_phys-1 in order.
  Pop on empty and push beyond num_phys are not guarded.
*/
`timescale 1ns/100ps

module free_list (
  input  logic                clock,
  input  logic                reset,
  input  logic                pop,
  output r10k_pkg::phys_tag_t head_t,
  output logic                empty,
  input  logic                push,
  input  r10k_pkg::phys_tag_t push_t
);
  import r10k_pkg::*;

  phys_tag_t                     tags [num_phys];
  logic [$clog2(num_phys)-1:0]   head_ptr;
  logic [$clog2(num_phys)-1:0]   tail_ptr;
  logic [$clog2(num_phys):0]     count;

  assign head_t = tags[head_ptr];
  assign empty  = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags below num_arch are held by the identity map
      for (int i = 0; i < num_phys; i++) begin
        if (i < num_phys - num_arch) begin
          tags[i] <= phys_tag_t'(i + num_arch);
        end
      end
      head_ptr <= '0;
      tail_ptr <= ($clog2(num_phys))'(num_phys - num_arch);
      count    <= ($clog2(num_phys) + 1)'(num_phys - num_arch);
    end else begin
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (push) begin
        tags[tail_ptr] <= push_t;
        tail_ptr       <= tail_ptr + 1'b1;
      end
      // simultaneous pop and push leaves the count alone
      if (pop && !push) begin
        count <= count - 1'b1;
      end else if (push && !pop) begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

//--- verilog/rename_core.sv
/*
  Rename and reorder core: reorder buffer, map table and free list.
  One dispatch and one retire per cycle; mispredict only while busy is low.
*/
`timescale 1ns/100ps

module rename_core (
  input  logic                clock,
  input  logic                reset,
  input  logic                dispatch_valid,
  input  r10k_pkg::arch_reg_t dispatch_arch,
  output logic                dispatch_ready,
  output r10k_pkg::phys_tag_t dispatch_t,
  output r10k_pkg::phys_tag_t dispatch_t_old,
  output r10k_pkg::rob_idx_t  dispatch_rob_idx,
  input  logic                retire,
  output logic                retire_valid,
  output r10k_pkg::phys_tag_t retire_t_old,
  input  logic                mispredict,
  input  r10k_pkg::rob_idx_t  mispredict_rob_idx,
  output logic                busy,
  output r10k_pkg::rob_idx_t  head_idx
);
  import r10k_pkg::*;

  logic      alloc;
  logic      free_empty;
  logic      free_push;
  phys_tag_t free_push_t;
  logic      undo_valid;
  arch_reg_t undo_arch;
  phys_tag_t undo_t_old;
  logic      map_write_en;
  arch_reg_t map_write_arch;
  phys_tag_t map_write_t;

  // undo restores T_old; otherwise dispatch maps to the new tag
  assign map_write_en   = alloc || undo_valid;
  assign map_write_arch = undo_valid ? undo_arch : dispatch_arch;
  assign map_write_t    = undo_valid ? undo_t_old : dispatch_t;

  reorder_buffer rob0 (
    .clock              (clock),
    .reset              (reset),
    .dispatch_valid     (dispatch_valid),
    .dispatch_arch      (dispatch_arch),
    .alloc_t            (dispatch_t),
    .alloc_t_old        (dispatch_t_old),
    .free_empty         (free_empty),
    .retire             (retire),
    .mispredict         (mispredict),
    .mispredict_rob_idx (mispredict_rob_idx),
    .dispatch_ready     (dispatch_ready),
    .dispatch_rob_idx   (dispatch_rob_idx),
    .alloc              (alloc),
    .retire_valid       (retire_valid),
    .retire_t_old       (retire_t_old),
    .free_push          (free_push),
    .free_push_t        (free_push_t),
    .busy               (busy),
    .undo_valid         (undo_valid),
    .undo_arch          (undo_arch),
    // undone T reaches the free list through free_push_t
    .undo_t             (),
    .undo_t_old         (undo_t_old),
    .head_idx           (head_idx)
  );

  map_table map0 (
    .clock      (clock),
    .reset      (reset),
    .read_arch  (dispatch_arch),
    .read_t     (dispatch_t_old),
    .write_en   (map_write_en),
    .write_arch (map_write_arch),
    .write_t    (map_write_t)
  );

  free_list free0 (
    .clock  (clock),
    .reset  (reset),
    .pop    (alloc),
    .head_t (dispatch_t),
    .empty  (free_empty),
    .push   (free_push),
    .push_t (free_push_t)
  );

endmodule

//--- sim/rename_core_sva.sv
/*
  Concurrent checks on the rename core handshakes and reset state.
  The reorder-buffer mode is reached through the bind connection.
*/
`timescale 1ns/100ps

module rename_core_sva (
  input logic                 clock,
  input logic                 reset,
  input logic                 mispredict,
  input r10k_pkg::rob_idx_t   dispatch_rob_idx,
  input r10k_pkg::rob_idx_t   head_idx,
  input logic                 retire_valid,
  input logic                 busy,
  input r10k_pkg::rob_state_t rob_state
);
  import r10k_pkg::*;

  // the walk-back only steps the tail back
  no_dispatch_while_busy: assert property (
    @(posedge clock) disable iff (reset)
      busy |=> (dispatch_rob_idx == $past(dispatch_rob_idx) - 1'b1)
  ) else $error("dispatch accepted while busy");

  // head stays put while entries are undone
  no_retire_while_busy: assert property (
    @(posedge clock) disable iff (reset) busy |=> (head_idx == $past(head_idx))
  ) else $error("retirement while busy");

  // first cycle out of reset
  idle_after_reset: assert property (
    @(posedge clock) ($past(reset) && !reset) |-> (!busy && !retire_valid)
  ) else $error("busy or retire_valid high right after reset");

  // squash mode is entered only from an accepted mispredict
  squash_after_mispredict: assert property (
    @(posedge clock) disable iff (reset)
      ((rob_state == rob_squash) && !$past(busy)) |-> $past(mispredict)
  ) else $error("walk-back started without a mispredict");

endmodule

bind rename_core rename_core_sva sva0 (
  .clock            (clock),
  .reset            (reset),
  .mispredict       (mispredict),
  .dispatch_rob_idx (dispatch_rob_idx),
  .head_idx         (head_idx),
  .retire_valid     (retire_valid),
  .busy             (busy),
  .rob_state        (rob0.state)
);

//--- sim/rename_core_tb.sv
/*
  Table-driven test of the rename core, followed by 200 random operations.
  A reference model of map, free queue and reorder queue predicts every output.
  Mispredict rows give the branch as an offset from the head.
*/
`timescale 1ns/100ps

module rename_core_tb;
  import r10k_pkg::*;

  localparam logic [1:0] op_dispatch   = 2'd0;
  localparam logic [1:0] op_retire     = 2'd1;
  localparam logic [1:0] op_mispredict = 2'd2;
  localparam logic [1:0] op_idle       = 2'd3;
  localparam int busy_timeout = 20;

  typedef struct packed {
    logic [1:0] kind;
    logic [2:0] arg;
    logic       level;
  } table_row_t;

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  arch_reg_t dispatch_arch;
  logic      dispatch_ready;
  phys_tag_t dispatch_t;
  phys_tag_t dispatch_t_old;
  rob_idx_t  dispatch_rob_idx;
  logic      retire;
  logic      retire_valid;
  phys_tag_t retire_t_old;
  logic      mispredict;
  rob_idx_t  mispredict_rob_idx;
  logic      busy;
  rob_idx_t  head_idx;

  // reference model
  int map_m [num_arch];
  int free_q [$];
  int rob_arch_q [$];
  int rob_t_q [$];
  int rob_told_q [$];
  int rob_head_m;
  int rob_tail_m;
  int squash_left;

  table_row_t  table_rows [$];
  logic        dispatch_held;
  logic        timed_out;
  logic [31:0] rng;
  int          errors;
  int          checks;

  rename_core dut0 (
    .clock              (clock),
    .reset              (reset),
    .dispatch_valid     (dispatch_valid),
    .dispatch_arch      (dispatch_arch),
    .dispatch_ready     (dispatch_ready),
    .dispatch_t         (dispatch_t),
    .dispatch_t_old     (dispatch_t_old),
    .dispatch_rob_idx   (dispatch_rob_idx),
    .retire             (retire),
    .retire_valid       (retire_valid),
    .retire_t_old       (retire_t_old),
    .mispredict         (mispredict),
    .mispredict_rob_idx (mispredict_rob_idx),
    .busy               (busy),
    .head_idx           (head_idx)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < num_arch; i++) begin
      map_m[i] = i;
    end
    free_q.delete();
    for (int t = num_arch; t < num_phys; t++) begin
      free_q.push_back(t);
    end
    rob_arch_q.delete();
    rob_t_q.delete();
    rob_told_q.delete();
    rob_head_m  = 0;
    rob_tail_m  = 0;
    squash_left = 0;
  endtask

  task automatic add_row(input logic [1:0] kind, input int arg, input logic level);
    table_row_t row;
    row.kind  = kind;
    row.arg   = arg[2:0];
    row.level = level;
    table_rows.push_back(row);
  endtask

  task automatic build_table();
    add_row(op_idle, 0, 1'b0);
    // chain on r1, then fill the buffer
    add_row(op_dispatch, 1, 1'b1);
    add_row(op_dispatch, 2, 1'b1);
    add_row(op_dispatch, 1, 1'b1);
    add_row(op_dispatch, 1, 1'b1);
    add_row(op_dispatch, 3, 1'b1);
    add_row(op_dispatch, 4, 1'b1);
    add_row(op_dispatch, 5, 1'b1);
    add_row(op_dispatch, 1, 1'b1);
    // full, dispatch held until a retirement frees a slot
    add_row(op_dispatch, 6, 1'b0);
    add_row(op_idle, 0, 1'b1);
    add_row(op_retire, 0, 1'b1);
    add_row(op_idle, 0, 1'b1);
    add_row(op_dispatch, 7, 1'b0);
    add_row(op_retire, 0, 1'b1);
    add_row(op_idle, 0, 1'b1);
    add_row(op_retire, 0, 1'b1);
    add_row(op_retire, 0, 1'b1);
    add_row(op_retire, 0, 1'b1);
    add_row(op_retire, 0, 1'b1);
    // four left, squash two, then none, then three
    add_row(op_mispredict, 1, 1'b1);
    add_row(op_dispatch, 7, 1'b1);
    add_row(op_dispatch, 6, 1'b1);
    add_row(op_mispredict, 3, 1'b0);
    add_row(op_mispredict, 0, 1'b1);
    add_row(op_dispatch, 1, 1'b1);
    add_row(op_retire, 0, 1'b1);
    add_row(op_retire, 0, 1'b1);
    add_row(op_retire, 0, 1'b0);
    add_row(op_idle, 0, 1'b0);
    add_row(op_dispatch, 2, 1'b1);
    add_row(op_dispatch, 2, 1'b1);
  endtask

  // check the cycle driven at the falling edge, then step the model
  task automatic check_and_advance();
    logic     exp_ready;
    logic     exp_rvalid;
    logic     acc_d;
    logic     acc_r;
    logic     acc_m;
    int       arch;
    int       last;
    int       offset;
    exp_ready  = (rob_t_q.size() < num_rob) && (free_q.size() > 0) &&
                 (squash_left == 0) && !mispredict;
    exp_rvalid = (rob_t_q.size() > 0) && (squash_left == 0) && !mispredict;
    compare_value("busy", busy, squash_left != 0);
    compare_value("dispatch_ready", dispatch_ready, exp_ready);
    compare_value("retire_valid", retire_valid, exp_rvalid);
    compare_value("head_idx", head_idx, rob_head_m);
    acc_d = dispatch_valid && exp_ready;
    acc_r = retire && exp_rvalid;
    acc_m = mispredict && (squash_left == 0);
    arch  = dispatch_arch;
    offset = (int'(mispredict_rob_idx) - rob_head_m + num_rob) % num_rob;
    if (acc_d) begin
      compare_value("dispatch_t", dispatch_t, free_q[0]);
      compare_value("dispatch_t_old", dispatch_t_old, map_m[arch]);
      compare_value("dispatch_rob_idx", dispatch_rob_idx, rob_tail_m);
    end
    if (acc_r) begin
      compare_value("retire_t_old", retire_t_old, rob_told_q[0]);
    end
    @(posedge clock);
    if (squash_left != 0) begin
      // youngest entry undone
      last = rob_t_q.size() - 1;
      map_m[rob_arch_q[last]] = rob_told_q[last];
      free_q.push_back(rob_t_q[last]);
      void'(rob_arch_q.pop_back());
      void'(rob_t_q.pop_back());
      void'(rob_told_q.pop_back());
      rob_tail_m = (rob_tail_m + num_rob - 1) % num_rob;
      squash_left--;
    end
    if (acc_r) begin
      free_q.push_back(rob_told_q[0]);
      void'(rob_arch_q.pop_front());
      void'(rob_t_q.pop_front());
      void'(rob_told_q.pop_front());
      rob_head_m = (rob_head_m + 1) % num_rob;
    end
    if (acc_d) begin
      rob_arch_q.push_back(arch);
      rob_t_q.push_back(free_q[0]);
      rob_told_q.push_back(map_m[arch]);
      map_m[arch] = free_q.pop_front();
      rob_tail_m = (rob_tail_m + 1) % num_rob;
      dispatch_held = 1'b0;
    end
    if (acc_m) begin
      squash_left = rob_t_q.size() - offset - 1;
    end
  endtask

  task automatic wait_busy_done(input int expected, input logic check_level,
                                input logic level);
    int busy_cycles;
    int waited;
    busy_cycles = 0;
    waited = 0;
    @(negedge clock);
    mispredict = 1'b0;
    dispatch_valid = dispatch_held;
    #1;
    if (check_level) begin
      compare_value("busy level", busy, level);
    end
    while (busy && waited < busy_timeout) begin
      busy_cycles++;
      check_and_advance();
      @(negedge clock);
      dispatch_valid = dispatch_held;
      #1;
      waited++;
    end
    if (busy) begin
      $display("timeout: busy still high after %0d walk-back cycles", busy_timeout);
      errors++;
      timed_out = 1'b1;
    end
    compare_value("busy cycles", busy_cycles, expected);
    check_and_advance();
  endtask

  task automatic run_op(input logic [1:0] kind, input int arg, input logic check_level,
                        input logic level);
    int younger;
    younger = 0;
    @(negedge clock);
    retire = 1'b0;
    mispredict = 1'b0;
    case (kind)
      op_dispatch: begin
        dispatch_held = 1'b1;
        dispatch_arch = arch_reg_t'(arg);
      end
      op_retire: begin
        retire = 1'b1;
      end
      op_mispredict: begin
        mispredict = 1'b1;
        mispredict_rob_idx = rob_idx_t'((rob_head_m + arg) % num_rob);
        younger = rob_t_q.size() - arg - 1;
      end
      default: begin
      end
    endcase
    dispatch_valid = dispatch_held;
    #1;
    if (check_level && kind == op_dispatch) begin
      compare_value("dispatch_ready level", dispatch_ready, level);
    end else if (check_level && kind != op_mispredict) begin
      compare_value("retire_valid level", retire_valid, level);
    end
    check_and_advance();
    if (kind == op_mispredict) begin
      wait_busy_done(younger, check_level, level);
    end
  endtask

  initial begin
    logic [2:0] sel;
    logic [1:0] kind;
    int         arg;
    reset = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_arch = '0;
    retire = 1'b0;
    mispredict = 1'b0;
    mispredict_rob_idx = '0;
    dispatch_held = 1'b0;
    timed_out = 1'b0;
    errors = 0;
    checks = 0;
    rng = 32'h89f4;
    reset_model();
    build_table();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    foreach (table_rows[i]) begin
      if (!timed_out) begin
        run_op(table_rows[i].kind, int'(table_rows[i].arg), 1'b1, table_rows[i].level);
      end
    end
    // random mix, mostly dispatch so the initial tags run out
    for (int n = 0; n < 200 && !timed_out; n++) begin
      rng = xorshift(rng);
      sel = rng[2:0];
      arg = int'(rng[10:8]);
      if (sel < 3'd4) begin
        kind = op_dispatch;
      end else if (sel < 3'd6) begin
        kind = op_retire;
      end else if (sel == 3'd6 && rob_t_q.size() > 0) begin
        kind = op_mispredict;
        arg = int'(rng[20:16]) % rob_t_q.size();
      end else begin
        kind = op_idle;
      end
      run_op(kind, arg, 1'b0, 1'b0);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- rename_core.f
verilog/r10k_pkg.sv
verilog/reorder_buffer.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/rename_core.sv
sim/rename_core_sva.sv
sim/rename_core_tb.sv
